//--- sim.f
+incdir+test
design/isaPkg.sv
design/execPkg.sv
design/instrDecoder.sv
design/alu.sv
design/xControl.sv
design/executeStage.sv
test/executeTb.sv

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator, verdict from the log
log=sim.log
rm -rf obj_dir "$log"
verilator --binary --timing --assert -f sim.f --top-module executeTb -o executeSim \
    > "$log" 2>&1 &&
    ./obj_dir/executeSim >> "$log" 2>&1 ||
    echo "Test failures found" >> "$log"
cat "$log"
grep -q "Test failures found" "$log" && exit 1 || exit 0

//--- test/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// R-type word, low two bits zero
function automatic logic [31:0] modelEncR(logic [4:0] rd, logic [4:0] rs, logic [4:0] rt,
                                          logic [4:0] shamt, isaPkg::aluOpT op);
    return {isaPkg::opRtype, rd, rs, rt, shamt, op, 2'b00};
endfunction

function automatic logic [31:0] modelEncI(isaPkg::opcodeT op, logic [4:0] rd, logic [4:0] rs,
                                          logic [16:0] imm);
    return {op, rd, rs, imm};
endfunction

function automatic logic [31:0] modelEncJ(isaPkg::opcodeT op, logic [26:0] target);
    return {op, target};
endfunction

function automatic logic [31:0] modelSext(logic [16:0] imm);
    return {{15{imm[16]}}, imm};
endfunction

// op the decoder should pick
function automatic isaPkg::aluOpT modelAluOp(logic [31:0] w);
    case (w[31:27])
        isaPkg::opRtype: return isaPkg::aluOpT'(w[6:2]);
        isaPkg::opBne, isaPkg::opBlt, isaPkg::opBeq: return isaPkg::aluSub;
        default: return isaPkg::aluAdd;
    endcase
endfunction

// full result for a word, B chosen as the stage does
function automatic logic [31:0] modelAlu(logic [31:0] w, logic [31:0] a, logic [31:0] rb);
    logic [31:0] b;
    b = (w[31:27] == isaPkg::opRtype || w[31:27] == isaPkg::opBne ||
         w[31:27] == isaPkg::opBlt || w[31:27] == isaPkg::opBeq) ? rb : modelSext(w[16:0]);
    case (modelAluOp(w))
        isaPkg::aluAdd: return a + b;
        isaPkg::aluSub: return a - b;
        isaPkg::aluAnd: return a & b;
        isaPkg::aluOr:  return a | b;
        isaPkg::aluSll: return a << w[11:7];
        isaPkg::aluSra: return $signed(a) >>> w[11:7];
        default:        return 32'h0;
    endcase
endfunction

function automatic logic modelTaken(logic [31:0] w, logic [31:0] a, logic [31:0] b,
                                    logic [31:0] rstatus, logic byp);
    case (w[31:27])
        isaPkg::opJ, isaPkg::opJal, isaPkg::opJr: return 1'b1;
        isaPkg::opBne: return a != b;
        isaPkg::opBlt: return $signed(a) > $signed(b);
        isaPkg::opBeq: return a == b;
        isaPkg::opBex: return (rstatus != 32'h0) || byp;
        default:       return 1'b0;
    endcase
endfunction

function automatic logic [31:0] modelTarget(logic [31:0] w, logic [31:0] pc, logic [31:0] b);
    case (w[31:27])
        isaPkg::opJ, isaPkg::opJal, isaPkg::opSetx, isaPkg::opBex: return {5'b0, w[26:0]};
        isaPkg::opJr: return b;
        isaPkg::opBne, isaPkg::opBlt, isaPkg::opBeq: return pc + modelSext(w[16:0]);
        default: return 32'h0;
    endcase
endfunction

`endif

//--- test/executeTb.sv
`timescale 1ns/1ps

module executeTb import isaPkg::*; ();

    `include "isaModel.svh"

    localparam int randPerOp   = 4;
    localparam int resetCycles = 16;
    // arith, branch/jump pairs, idle pairs, mul/div, drain
    localparam int plannedSlots = 9*randPerOp + 2*(9 + 4 + 4) + 4 + 3 + 4;

    typedef struct packed {
        logic [31:0] issueCyc;
        logic        valid;
        logic [31:0] result;
        logic        taken;
        logic [31:0] target;
        logic        jal, setx, mul, div;
    } slotExpT;

    logic        clock, arstN, inValid, bypExcpt;
    logic [31:0] instr, pc, regA, regB, rstatus;
    logic        outValid, branchTaken, jal, setx, multStart, divStart;
    logic [31:0] aluResult, branchTarget;

    slotExpT     expQ[$];        // one entry per issued slot, in order
    logic        expLive;        // expected values below belong to the outputs now
    logic        expValid, expTaken, expJal, expSetx, expMul, expDiv;
    logic [31:0] expResult, expTarget;
    logic        prevTaken;      // last issued slot redirects
    int          cycleCnt, valueErrors, otherErrors;

    executeStage uut (.*);

    always #50 clock = ~clock;
    always @(posedge clock) cycleCnt <= cycleCnt + 1;

    // slot issued in cycle n sits in the output register during cycle n+2
    always @(negedge clock) begin
        slotExpT e;
        expLive = 1'b0;
        if (expQ.size() > 0 && int'(expQ[0].issueCyc) == cycleCnt - 2) begin
            e = expQ.pop_front();
            {expValid, expResult, expTaken, expTarget} = {e.valid, e.result, e.taken, e.target};
            {expJal, expSetx, expMul, expDiv} = {e.jal, e.setx, e.mul, e.div};
            expLive = 1'b1;
        end
    end

    task automatic reportMismatch(string name, logic [31:0] expVal, logic [31:0] actVal);
        $display("CHECK FAILED time=%0t signal=%s expected=%h actual=%h",
                 $time, name, expVal, actVal);
        valueErrors++;
    endtask

    task automatic reportProblem(string what);
        $display("ERROR at %0t: %s", $time, what);
        otherErrors++;
    endtask

    assert property (@(posedge clock) $rose(arstN) |->
                     !(outValid | branchTaken | jal | setx | multStart | divStart))
        else reportProblem("stage outputs not all low right after reset");
    assert property (@(posedge clock) disable iff (!arstN) expLive |-> outValid == expValid)
        else reportMismatch("outValid", 32'($sampled(expValid)), 32'($sampled(outValid)));
    assert property (@(posedge clock) disable iff (!arstN)
                     expLive && expValid |-> aluResult == expResult)
        else reportMismatch("aluResult", $sampled(expResult), $sampled(aluResult));
    assert property (@(posedge clock) disable iff (!arstN) expLive |-> branchTaken == expTaken)
        else reportMismatch("branchTaken", 32'($sampled(expTaken)), 32'($sampled(branchTaken)));
    assert property (@(posedge clock) disable iff (!arstN)
                     expLive && expValid |-> branchTarget == expTarget)
        else reportMismatch("branchTarget", $sampled(expTarget), $sampled(branchTarget));
    assert property (@(posedge clock) disable iff (!arstN)
                     expLive |-> jal == expJal && setx == expSetx)
        else reportMismatch("jal/setx", 32'({$sampled(expJal), $sampled(expSetx)}),
                            32'({$sampled(jal), $sampled(setx)}));
    assert property (@(posedge clock) disable iff (!arstN)
                     expLive |-> multStart == expMul && divStart == expDiv)
        else reportMismatch("multStart/divStart", 32'({$sampled(expMul), $sampled(expDiv)}),
                            32'({$sampled(multStart), $sampled(divStart)}));

    function automatic logic [4:0] randIdx();
        return 5'($urandom);
    endfunction

    // drive one slot 5 ns after the edge, queue what should come out
    task automatic issue(logic valid, logic [31:0] w, logic [31:0] a, logic [31:0] b,
                         logic [31:0] stat, logic byp);
        slotExpT     e;
        logic [31:0] p;
        @(posedge clock);
        #5;
        p        = $urandom;
        inValid  = valid;
        instr    = w;
        pc       = p;
        regA     = a;
        regB     = b;
        rstatus  = stat;
        bypExcpt = byp;
        e.issueCyc = 32'(cycleCnt);
        e.valid  = valid & ~prevTaken;   // dies right behind a redirect
        e.result = modelAlu(w, a, b);
        e.taken  = e.valid & modelTaken(w, a, b, stat, byp);
        e.target = modelTarget(w, p, b);
        e.jal    = e.valid & (w[31:27] == opJal);
        e.setx   = e.valid & (w[31:27] == opSetx);
        e.mul    = e.valid & (w[31:27] == opRtype) & (modelAluOp(w) == aluMul);
        e.div    = e.valid & (w[31:27] == opRtype) & (modelAluOp(w) == aluDiv);
        prevTaken = e.taken;
        expQ.push_back(e);
    endtask

    task automatic issueAdd(); // filler, shows squash when behind a redirect
        issue(1'b1, modelEncR(randIdx(), randIdx(), randIdx(), 5'd0, aluAdd),
              $urandom, $urandom, 32'h0, 1'b0);
    endtask

    initial begin
        aluOpT       ops[6];
        opcodeT      iOps[3], brOps[3], jOps[4];
        logic [31:0] lo, hi, a, b;
        ops   = '{aluAdd, aluSub, aluAnd, aluOr, aluSll, aluSra};
        iOps  = '{opAddi, opLw, opSw};
        brOps = '{opBne, opBlt, opBeq};
        jOps  = '{opJ, opJal, opJr, opSetx};
        void'($urandom(32'h39c7b59c));
        {clock, arstN, inValid, bypExcpt} = 4'b0;
        {instr, pc, regA, regB, rstatus} = '0;
        {cycleCnt, valueErrors, otherErrors} = '0;
        {prevTaken, expLive} = 2'b0;
        repeat (resetCycles) @(posedge clock);
        #5 arstN = 1'b1;

        foreach (ops[k]) repeat (randPerOp)
            issue(1'b1, modelEncR(randIdx(), randIdx(), randIdx(), randIdx(), ops[k]),
                  $urandom, $urandom, 32'h0, 1'b0);
        foreach (iOps[k]) repeat (randPerOp)
            issue(1'b1, modelEncI(iOps[k], randIdx(), randIdx(), 17'($urandom)),
                  $urandom, $urandom, 32'h0, 1'b0);
        foreach (brOps[k]) begin
            for (int n = 0; n < 3; n++) begin
                lo = $signed($urandom) >>> 2;            // headroom, no overflow
                hi = lo + 32'($urandom & 32'hffff) + 32'd1;
                a  = (n == 2) ? hi : lo;                 // equal, less, greater
                b  = (n == 1) ? hi : lo;
                issue(1'b1, modelEncI(brOps[k], randIdx(), randIdx(), 17'($urandom)),
                      a, b, 32'h0, 1'b0);
                issueAdd();
            end
        end
        for (int n = 0; n < 4; n++) begin // every rstatus / bypass pair
            issue(1'b1, modelEncJ(opBex, 27'($urandom)), $urandom, $urandom,
                  n[0] ? ($urandom | 32'h1) : 32'h0, n[1]);
            issueAdd();
        end
        foreach (jOps[k]) begin
            issue(1'b1, modelEncJ(jOps[k], 27'($urandom)), $urandom, $urandom, 32'h0, 1'b0);
            issueAdd();
        end
        repeat (2) begin // invalid jump must not squash
            issue(1'b0, modelEncJ(opJ, 27'($urandom)), $urandom, $urandom, 32'h0, 1'b0);
            issueAdd();
        end
        issue(1'b1, modelEncR(randIdx(), randIdx(), randIdx(), 5'd0, aluMul),
              $urandom, $urandom, 32'h0, 1'b0);
        issue(1'b1, modelEncR(randIdx(), randIdx(), randIdx(), 5'd0, aluDiv),
              $urandom, $urandom, 32'h0, 1'b0);
        issue(1'b0, modelEncR(randIdx(), randIdx(), randIdx(), 5'd0, aluMul),
              $urandom, $urandom, 32'h0, 1'b0);
        repeat (4) issue(1'b0, 32'h0, 32'h0, 32'h0, 32'h0, 1'b0); // drain

        while (expQ.size() > 0) @(posedge clock);
        repeat (2) @(posedge clock); // last compare fires
        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin // watchdog
        #((plannedSlots + 40) * 100);
        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        $display("run did not finish within %0d cycles", plannedSlots + 40);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- design/executeStage.sv
`timescale 1ns/1ps

module executeStage import isaPkg::*; (
    input  logic                 clock,
    input  logic                 arstN,
    input  logic                 inValid,
    input  logic [wordWidth-1:0] instr,
    input  logic [wordWidth-1:0] pc,
    input  logic [wordWidth-1:0] regA,
    input  logic [wordWidth-1:0] regB,
    input  logic [wordWidth-1:0] rstatus,
    input  logic                 bypExcpt,
    output logic                 outValid,
    output logic [wordWidth-1:0] aluResult,
    output logic                 branchTaken,
    output logic [wordWidth-1:0] branchTarget,
    output logic                 jal,
    output logic                 setx,
    output logic                 multStart,
    output logic                 divStart
);

    // D/X slot register
    logic                 slotValid;
    logic [wordWidth-1:0] slotInstr, slotPc, slotRegA, slotRegB, slotRstatus;
    logic                 slotBypExcpt;
    logic                 slotLive;     // valid and not behind a taken redirect

    opcodeT                 opcode;
    aluOpT                  aluOp;
    logic [regIdxWidth-1:0] shamt;
    logic [immWidth-1:0]    imm;
    logic [targetWidth-1:0] target;

    logic                 aluInB;
    logic [wordWidth-1:0] imm32, aluB, result, targetActual;
    logic                 ne, lt, taken, isJal, isSetx, mulGo, divGo;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) slotValid <= 1'b0;
        else        slotValid <= inValid;
    end

    always_ff @(posedge clock) begin // slot payload
        slotInstr    <= instr;
        slotPc       <= pc;
        slotRegA     <= regA;
        slotRegB     <= regB;
        slotRstatus  <= rstatus;
        slotBypExcpt <= bypExcpt;
    end

    instrDecoder dec (
        .instr(slotInstr), .opcode(opcode), .rd(), .rs(), .rt(),
        .shamt(shamt), .aluOp(aluOp), .imm(imm), .target(target)
    );

    assign aluB = aluInB ? imm32 : slotRegB; // I-type takes the immediate

    alu exAlu (
        .a(slotRegA), .b(aluB), .aluOp(aluOp), .shamt(shamt),
        .result(result), .ne(ne), .lt(lt)
    );

    xControl ctl (
        .opcode(opcode), .aluOp(aluOp), .imm(imm), .target(target), .pc(slotPc),
        .regB(slotRegB), .ne(ne), .lt(lt), .rstatus(slotRstatus), .bypExcpt(slotBypExcpt),
        .aluInB(aluInB), .imm32(imm32), .multStart(mulGo), .divStart(divGo),
        .taken(taken), .targetActual(targetActual), .jal(isJal), .setx(isSetx)
    );

    // squash the slot right behind a redirect already in the X/M register
    assign slotLive = slotValid & ~branchTaken;

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            outValid    <= 1'b0;
            branchTaken <= 1'b0;
            jal         <= 1'b0;
            setx        <= 1'b0;
            multStart   <= 1'b0;
            divStart    <= 1'b0;
        end else begin
            outValid    <= slotLive;
            branchTaken <= slotLive & taken;
            jal         <= slotLive & isJal;
            setx        <= slotLive & isSetx;
            multStart   <= slotLive & mulGo;  // one-cycle strobe
            divStart    <= slotLive & divGo;
        end
    end

    always_ff @(posedge clock) begin
        aluResult    <= result;
        branchTarget <= targetActual;
    end

    // decoded op must be known whenever a real slot sits in the register
    assert property (@(posedge clock) disable iff (!arstN) slotValid |-> !$isunknown(aluOp));
    assert property (@(posedge clock) disable iff (!arstN) branchTaken |-> outValid);

endmodule

//--- design/xControl.sv
`timescale 1ns/1ps

module xControl import isaPkg::*; import execPkg::*; (
    input  opcodeT                 opcode,
    input  aluOpT                  aluOp,
    input  logic [immWidth-1:0]    imm,
    input  logic [targetWidth-1:0] target,
    input  logic [wordWidth-1:0]   pc,
    input  logic [wordWidth-1:0]   regB,
    input  logic                   ne,
    input  logic                   lt,
    input  logic [wordWidth-1:0]   rstatus,
    input  logic                   bypExcpt,
    output logic                   aluInB,      // 1: B from imm32
    output logic [wordWidth-1:0]   imm32,
    output logic                   multStart,
    output logic                   divStart,
    output logic                   taken,
    output logic [wordWidth-1:0]   targetActual,
    output logic                   jal,
    output logic                   setx
);

    logic isRtype, isJ, isJr, isBne, isBlt, isBeq, isBex;
    logic isBranch;
    logic excPending;                  // bex condition
    logic [wordWidth-1:0] target32;
    logic [wordWidth-1:0] pcPlusImm;
    tgtSrcT tgtSrc;

    // one-hot opcode flags
    assign isRtype = (opcode == opRtype);
    assign isJ     = (opcode == opJ);
    assign jal     = (opcode == opJal);
    assign isJr    = (opcode == opJr);
    assign isBne   = (opcode == opBne);
    assign isBlt   = (opcode == opBlt);
    assign isBeq   = (opcode == opBeq);
    assign setx    = (opcode == opSetx);
    assign isBex   = (opcode == opBex);

    assign isBranch = isBne | isBlt | isBeq;
    assign aluInB   = ~isRtype & ~isBranch; // branches compare two registers

    assign imm32     = {{(wordWidth-immWidth){imm[immWidth-1]}}, imm}; // sign-extend
    assign target32  = {{(wordWidth-targetWidth){1'b0}}, target};     // zero-extend
    assign pcPlusImm = pc + imm32;

    // strobes to the mult/div unit, only R-type can carry these ops
    assign multStart = (aluOp == aluMul);
    assign divStart  = (aluOp == aluDiv);

    // target source select
    always_comb begin
        if (isJ | jal | setx | isBex) tgtSrc = tgtAbs;
        else if (isJr)                tgtSrc = tgtReg;
        else if (isBranch)            tgtSrc = tgtRel;
        else                          tgtSrc = tgtNone;
    end

    always_comb begin
        case (tgtSrc)
            tgtAbs:  targetActual = target32;
            tgtReg:  targetActual = regB;      // jr $rd
            tgtRel:  targetActual = pcPlusImm;
            default: targetActual = '0;
        endcase
    end

    assign excPending = (rstatus != statusOk) | bypExcpt;

    // taken rule, setx writes rstatus and never redirects
    assign taken = isJ | jal | isJr
                 | (isBne & ne)
                 | (isBlt & ~lt & ne) // lt is rs < rd, want rd < rs
                 | (isBeq & ~ne)
                 | (isBex & excPending);

    // decode must never select two opcodes at once
    always_comb begin
        if (!$isunknown(opcode)) begin
            assert ($onehot0({isRtype, isJ, jal, isJr, isBne, isBlt, isBeq, setx, isBex}))
                else $error("xControl: opcode %b decodes to several flags", opcode);
        end
    end

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu import isaPkg::*; (
    input  logic [wordWidth-1:0]   a,
    input  logic [wordWidth-1:0]   b,
    input  aluOpT                  aluOp,
    input  logic [regIdxWidth-1:0] shamt,
    output logic [wordWidth-1:0]   result,
    output logic                   ne,
    output logic                   lt
);

    logic [wordWidth-1:0] sum;    // a + b
    logic [wordWidth-1:0] diff;   // a - b
    logic [wordWidth-1:0] shl;
    logic [wordWidth-1:0] shra;

    assign sum  = a + b;
    assign diff = a - b;
    assign shl  = a << shamt;            // shift amount from the word, not b
    assign shra = $signed(a) >>> shamt;  // sign bit fills from the top

    always_comb begin
        case (aluOp)
            aluAdd:  result = sum;
            aluSub:  result = diff;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluSll:  result = shl;
            aluSra:  result = shra;
            // mul/div only kick off the external unit
            aluMul:  result = '0;
            aluDiv:  result = '0;
            default: result = '0;
        endcase
    end

    // compare flags for the branch logic
    assign ne = (a != b);
    assign lt = ($signed(a) < $signed(b)); // signed a < b

endmodule

//--- design/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder import isaPkg::*; (
    input  logic [wordWidth-1:0]   instr,
    output opcodeT                 opcode,
    output logic [regIdxWidth-1:0] rd,
    output logic [regIdxWidth-1:0] rs,
    output logic [regIdxWidth-1:0] rt,
    output logic [regIdxWidth-1:0] shamt,
    output aluOpT                  aluOp,
    output logic [immWidth-1:0]    imm,
    output logic [targetWidth-1:0] target
);

    // field positions, msb down
    localparam int rdLsb    = targetWidth - regIdxWidth; // 22
    localparam int rsLsb    = rdLsb - regIdxWidth;       // 17
    localparam int rtLsb    = rsLsb - regIdxWidth;       // 12
    localparam int shamtLsb = rtLsb - regIdxWidth;       // 7
    localparam int aluOpLsb = shamtLsb - aluOpWidth;     // 2, low two bits unused

    assign opcode = opcodeT'(instr[wordWidth-1 -: opWidth]);
    assign rd     = instr[rdLsb    +: regIdxWidth];
    assign rs     = instr[rsLsb    +: regIdxWidth];
    assign rt     = instr[rtLsb    +: regIdxWidth];
    assign shamt  = instr[shamtLsb +: regIdxWidth];
    assign imm    = instr[immWidth-1:0];    // overlaps rt/shamt/aluOp
    assign target = instr[targetWidth-1:0]; // J-type, overlaps everything below opcode

    // ALU op: from the word for R-type, forced otherwise
    always_comb begin
        case (opcode)
            opRtype:             aluOp = aluOpT'(instr[aluOpLsb +: aluOpWidth]);
            opAddi, opLw, opSw:  aluOp = aluAdd; // address / immediate add
            opBne, opBlt, opBeq: aluOp = aluSub; // compare through the subtractor
            default:             aluOp = aluAdd; // jumps, setx, bex don't care
        endcase
    end

endmodule

//--- design/execPkg.sv
package execPkg;

    import isaPkg::*;

    // where the redirect target of the execute slot comes from
    typedef enum logic [1:0] {
        tgtNone = 2'd0, // no redirect
        tgtAbs  = 2'd1, // {5'b0, target}
        tgtReg  = 2'd2, // register operand B, jr
        tgtRel  = 2'd3  // pc + sign-extended imm, branches
    } tgtSrcT;

    // rstatus value meaning no exception pending, bex redirects on anything else
    localparam logic [wordWidth-1:0] statusOk = '0;

endpackage

//--- design/isaPkg.sv
package isaPkg;

    localparam int wordWidth   = 32; // data and address width
    localparam int opWidth     = 5;  // top five bits of the word
    localparam int aluOpWidth  = 5;
    localparam int regIdxWidth = 5;  // rd, rs, rt, shamt
    localparam int immWidth    = 17; // I-type immediate, sign-extended later
    localparam int targetWidth = 27; // J-type target, zero-extended later

    // primary opcodes
    typedef enum logic [opWidth-1:0] {
        opRtype = 5'b00000,
        opJ     = 5'b00001,
        opBne   = 5'b00010,
        opJal   = 5'b00011,
        opJr    = 5'b00100,
        opAddi  = 5'b00101,
        opBlt   = 5'b00110,
        opSw    = 5'b00111,
        opLw    = 5'b01000,
        opBeq   = 5'b11001,
        opSetx  = 5'b10101,
        opBex   = 5'b10110
    } opcodeT;

    // R-type function field, also forced by the decoder for I-type and branches
    typedef enum logic [aluOpWidth-1:0] {
        aluAdd = 5'b00000,
        aluSub = 5'b00001,
        aluAnd = 5'b00010,
        aluOr  = 5'b00011,
        aluSll = 5'b00100,
        aluSra = 5'b00101,
        aluMul = 5'b00110, // handed to the external mult/div unit
        aluDiv = 5'b00111
    } aluOpT;

endpackage
